/* verilog/soc_pkg.sv */
package soc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone classic bus types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Master to slave.
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
	} wb_req_t;

	// Slave to master.
	typedef struct packed {
		logic        ack;
		logic        err;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef enum logic [1:0] {
		SLV_RAM  = 2'd0,
		SLV_PRG  = 2'd1,
		SLV_GPIO = 2'd2,
		SLV_NONE = 2'd3
	} slave_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
	localparam logic [31:0] PRG_BASE  = 32'h0400_0000;
	localparam logic [31:0] GPIO_BASE = 32'h0200_0000;

	localparam logic [31:0] RAM_MASK  = 32'hff00_0000;
	localparam logic [31:0] PRG_MASK  = 32'hff00_0000;
	localparam logic [31:0] GPIO_MASK = 32'hffff_ffc0;

	// Byte offsets inside the 64-byte GPIO window.
	localparam logic [5:0] GPIO_OUT_OFS = 6'h00;
	localparam logic [5:0] GPIO_IN_OFS  = 6'h04;

	function automatic logic addr_hit(input logic [31:0] adr, input logic [31:0] base,
			input logic [31:0] mask);
		return (adr & mask) == base;
	endfunction

endpackage

/* verilog/wb_addr_decoder.sv */
`timescale 1ns/1ps

module wb_addr_decoder import soc_pkg::*; (
	input  wb_req_t wbm_req_i,
	output wb_req_t ram_req_o,
	output wb_req_t prg_req_o,
	output wb_req_t gpio_req_o,
	output slave_e  slv_sel_o
);

	logic hit_ram;
	logic hit_prg;
	logic hit_gpio;

	assign hit_ram  = addr_hit(wbm_req_i.adr, RAM_BASE, RAM_MASK);
	assign hit_prg  = addr_hit(wbm_req_i.adr, PRG_BASE, PRG_MASK);
	assign hit_gpio = addr_hit(wbm_req_i.adr, GPIO_BASE, GPIO_MASK);

	// Regions do not overlap, order only matters for a bad map.
	always_comb begin
		if (hit_ram) begin
			slv_sel_o = SLV_RAM;
		end else if (hit_prg) begin
			slv_sel_o = SLV_PRG;
		end else if (hit_gpio) begin
			slv_sel_o = SLV_GPIO;
		end else begin
			slv_sel_o = SLV_NONE;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Per-slave request copies
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Payload fans out to all, cyc/stb only to the winner.
	always_comb begin
		ram_req_o     = wbm_req_i;
		ram_req_o.cyc = wbm_req_i.cyc & (slv_sel_o == SLV_RAM);
		ram_req_o.stb = wbm_req_i.stb & (slv_sel_o == SLV_RAM);
	end

	always_comb begin
		prg_req_o     = wbm_req_i;
		prg_req_o.cyc = wbm_req_i.cyc & (slv_sel_o == SLV_PRG);
		prg_req_o.stb = wbm_req_i.stb & (slv_sel_o == SLV_PRG);
	end

	always_comb begin
		gpio_req_o     = wbm_req_i;
		gpio_req_o.cyc = wbm_req_i.cyc & (slv_sel_o == SLV_GPIO);
		gpio_req_o.stb = wbm_req_i.stb & (slv_sel_o == SLV_GPIO);
	end

endmodule

/* verilog/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram import soc_pkg::*; #(
	parameter int WORD_COUNT = 256
) (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int AW = (WORD_COUNT > 1) ? $clog2(WORD_COUNT) : 1;

	logic [31:0]   mem [WORD_COUNT];
	logic [AW-1:0] idx;
	logic          stb_hit;
	logic          ack_q;
	logic [31:0]   dat_q;

	// Word index, wraps inside the region.
	assign idx = AW'(req_i.adr[31:2] % WORD_COUNT);

	// Held stb is ignored while ack is up.
	assign stb_hit = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			dat_q <= '0;
		end else begin
			ack_q <= stb_hit;
			if (stb_hit && !req_i.we) begin
				dat_q <= mem[idx];
			end else begin
				dat_q <= '0;
			end
		end
	end

	// Byte lane writes.
	always_ff @(posedge clk) begin
		if (stb_hit && req_i.we) begin
			for (int b = 0; b < 4; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
	end

	assign rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};

endmodule

/* verilog/wb_gpio.sv */
`timescale 1ns/1ps

module wb_gpio import soc_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  wb_req_t     req_i,
	output wb_rsp_t     rsp_o,
	input  logic [31:0] gpio_i,
	output logic [31:0] gpio_o
);

	logic        stb_hit;
	logic        is_out;
	logic        is_in;
	logic        ack_q;
	logic [31:0] dat_q;
	logic [31:0] rd_dat;
	logic [31:0] out_q;
	logic [31:0] in_meta_q;
	logic [31:0] in_sync_q;

	assign stb_hit = req_i.cyc & req_i.stb & ~ack_q;
	assign is_out  = req_i.adr[5:2] == GPIO_OUT_OFS[5:2];
	assign is_in   = req_i.adr[5:2] == GPIO_IN_OFS[5:2];

	// Unused offsets read as zero.
	always_comb begin
		if (is_out) begin
			rd_dat = out_q;
		end else if (is_in) begin
			rd_dat = in_sync_q;
		end else begin
			rd_dat = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q     <= 1'b0;
			dat_q     <= '0;
			out_q     <= '0;
			in_meta_q <= '0;
			in_sync_q <= '0;
		end else begin
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Input synchronizer
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			in_meta_q <= gpio_i;
			in_sync_q <= in_meta_q;

			ack_q <= stb_hit;
			dat_q <= (stb_hit && !req_i.we) ? rd_dat : '0;
			if (stb_hit && req_i.we && is_out) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.sel[b]) begin
						out_q[8*b +: 8] <= req_i.dat[8*b +: 8];
					end
				end
			end
		end
	end

	assign gpio_o = out_q;
	assign rsp_o  = '{ack: ack_q, err: 1'b0, dat: dat_q};

endmodule

/* verilog/wb_resp_mux.sv */
`timescale 1ns/1ps

module wb_resp_mux import soc_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	input  slave_e  slv_sel_i,
	input  wb_req_t wbm_req_i,
	input  wb_rsp_t ram_rsp_i,
	input  wb_rsp_t prg_rsp_i,
	input  wb_rsp_t gpio_rsp_i,
	output wb_rsp_t wbm_rsp_o
);

	logic none_hit;
	logic err_q;

	// Unmapped access, err pulses once per strobe.
	assign none_hit = wbm_req_i.cyc & wbm_req_i.stb & (slv_sel_i == SLV_NONE) & ~err_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= none_hit;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Response select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Address is held through ack, so select is still valid here.
	always_comb begin
		case (slv_sel_i)
			SLV_RAM: begin
				wbm_rsp_o = ram_rsp_i;
			end
			SLV_PRG: begin
				wbm_rsp_o = prg_rsp_i;
			end
			SLV_GPIO: begin
				wbm_rsp_o = gpio_rsp_i;
			end
			default: begin
				wbm_rsp_o = '{ack: 1'b0, err: err_q, dat: 32'h0};
			end
		endcase
	end

endmodule

/* verilog/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
	parameter int RAM_WORDS = 256,
	parameter int PRG_WORDS = 4096
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  wb_req_t     wbm_req_i,
	output wb_rsp_t     wbm_rsp_o,
	input  logic [31:0] gpio_i,
	output logic [31:0] gpio_o
);

	wb_req_t ram_req;
	wb_req_t prg_req;
	wb_req_t gpio_req;
	wb_rsp_t ram_rsp;
	wb_rsp_t prg_rsp;
	wb_rsp_t gpio_rsp;
	slave_e  slv_sel;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	wb_addr_decoder u_decoder (
		.wbm_req_i  (wbm_req_i),
		.ram_req_o  (ram_req),
		.prg_req_o  (prg_req),
		.gpio_req_o (gpio_req),
		.slv_sel_o  (slv_sel)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slaves
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	wb_ram #(
		.WORD_COUNT (RAM_WORDS)
	) data_ram (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (ram_req),
		.rsp_o   (ram_rsp)
	);

	// Program memory, same RAM with a larger array.
	wb_ram #(
		.WORD_COUNT (PRG_WORDS)
	) prg_ram (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (prg_req),
		.rsp_o   (prg_rsp)
	);

	wb_gpio u_gpio (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.req_i   (gpio_req),
		.rsp_o   (gpio_rsp),
		.gpio_i  (gpio_i),
		.gpio_o  (gpio_o)
	);

	wb_resp_mux u_resp_mux (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.slv_sel_i  (slv_sel),
		.wbm_req_i  (wbm_req_i),
		.ram_rsp_i  (ram_rsp),
		.prg_rsp_i  (prg_rsp),
		.gpio_rsp_i (gpio_rsp),
		.wbm_rsp_o  (wbm_rsp_o)
	);

endmodule

/* tests/soc_properties.sv */
`timescale 1ns/1ps

module soc_properties import soc_pkg::*; (
	input logic    clk,
	input logic    rst_n_i,
	input wb_req_t wbm_req_i,
	input wb_rsp_t wbm_rsp_o
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Master handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	property ack_err_exclusive;
		@(posedge clk) disable iff (!rst_n_i)
		!(wbm_rsp_o.ack && wbm_rsp_o.err);
	endproperty

	// A fresh strobe is answered on the next edge.
	property strobe_answered;
		@(posedge clk) disable iff (!rst_n_i)
		(wbm_req_i.cyc && wbm_req_i.stb && !wbm_rsp_o.ack && !wbm_rsp_o.err)
			|=> (wbm_rsp_o.ack || wbm_rsp_o.err);
	endproperty

	property no_spurious_response;
		@(posedge clk) disable iff (!rst_n_i)
		(wbm_rsp_o.ack || wbm_rsp_o.err) |-> $past(wbm_req_i.cyc && wbm_req_i.stb);
	endproperty

	assert property (ack_err_exclusive) else $error("ack and err high in the same cycle");
	assert property (strobe_answered) else $error("strobe not answered after one cycle");
	assert property (no_spurious_response) else $error("response without a prior strobe");

endmodule

bind soc_top soc_properties u_props (
	.clk       (clk),
	.rst_n_i   (rst_n_i),
	.wbm_req_i (wbm_req_i),
	.wbm_rsp_o (wbm_rsp_o)
);

/* tests/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RAM_WORDS  = 256;
	localparam int PRG_WORDS  = 4096;
	localparam int N_RAM      = 64;
	localparam int N_PRG      = 64;
	localparam int N_GPIO     = 16;
	localparam int N_BAD      = 32;
	localparam int XFER_LIMIT = 8;
	localparam logic [31:0] SEED = 32'he231c2e1;

	// Upper bound on transfers with all rechecks.
	localparam int MAX_XFERS       = 7*N_RAM + 4*N_PRG + 3*N_GPIO + N_BAD + 2;
	localparam int WATCHDOG_CYCLES = MAX_XFERS*4 + 200;

	logic        clk;
	logic        rst_n;
	wb_req_t     wbm_req;
	wb_rsp_t     wbm_rsp;
	logic [31:0] gpio_in;
	logic [31:0] gpio_out;

	// Model of both RAMs by canonical word address.
	logic [31:0] model_m [logic [31:0]];
	logic [31:0] gpio_out_m;
	int          n_checks;
	int          n_errors;
	int          n_tests;

	soc_top #(
		.RAM_WORDS (RAM_WORDS),
		.PRG_WORDS (PRG_WORDS)
	) uut (
		.clk       (clk),
		.rst_n_i   (rst_n),
		.wbm_req_i (wbm_req),
		.wbm_rsp_o (wbm_rsp),
		.gpio_i    (gpio_in),
		.gpio_o    (gpio_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Model helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic slave_e decode_region(input logic [31:0] adr);
		if ((adr & RAM_MASK) == RAM_BASE) begin
			return SLV_RAM;
		end else if ((adr & PRG_MASK) == PRG_BASE) begin
			return SLV_PRG;
		end else if ((adr & GPIO_MASK) == GPIO_BASE) begin
			return SLV_GPIO;
		end
		return SLV_NONE;
	endfunction

	function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdat,
			input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = wdat[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		n_tests++;
		$display("[%s] finished, %0d errors", name, n_errors - err_start);
	endtask

	// One classic cycle. Called right after a rising edge.
	task automatic bus_xfer(input string name, input logic we, input logic [31:0] adr,
			input logic [31:0] wdat, input logic [3:0] sel, output wb_rsp_t rsp);
		int waited;
		waited  = 0;
		wbm_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: sel};
		do begin
			@(posedge clk);
			waited++;
		end while (!wbm_rsp.ack && !wbm_rsp.err && waited < XFER_LIMIT);
		rsp = wbm_rsp;
		if (!wbm_rsp.ack && !wbm_rsp.err) begin
			n_errors++;
			$display("Timeout in %s: no ack or err for address 0x%08h", name, adr);
		end else begin
			// Counts the sampling edge and the response edge.
			check({name, " latency"}, 32'd2, 32'(waited));
		end
		wbm_req.cyc <= 1'b0;
		wbm_req.stb <= 1'b0;
		@(posedge clk);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic ram_traffic(input string name, input logic [31:0] base, input int words,
			input int count);
		int          w;
		int          slot[$];
		logic [31:0] key;
		logic [31:0] wdat;
		logic [3:0]  sel;
		wb_rsp_t     rsp;
		for (int i = 0; i < count; i++) begin
			// Indices up to four times the depth alias.
			w    = $urandom_range(4*words - 1, 0);
			key  = base | (32'(w % words) << 2);
			wdat = $urandom;
			sel  = 4'($urandom);
			// First write to a word sets all lanes.
			if (!model_m.exists(key)) begin
				sel          = 4'hf;
				model_m[key] = '0;
			end
			bus_xfer(name, 1'b1, base | (32'(w) << 2), wdat, sel, rsp);
			check(name, 32'd1, 32'(rsp.ack));
			check(name, 32'd0, rsp.dat);
			model_m[key] = merge_lanes(model_m[key], wdat, sel);
			slot.push_back(w % words);
		end
		for (int i = 0; i < count; i++) begin
			w   = slot[$urandom_range(slot.size() - 1, 0)];
			key = base | (32'(w) << 2);
			w   = w + words * int'($urandom_range(3, 0));
			bus_xfer(name, 1'b0, base | (32'(w) << 2), 32'h0, 4'h0, rsp);
			check(name, 32'd1, 32'(rsp.ack));
			check(name, model_m[key], rsp.dat);
		end
	endtask

	task automatic recheck_region(input string name, input slave_e slv);
		wb_rsp_t rsp;
		foreach (model_m[key]) begin
			if (decode_region(key) == slv) begin
				bus_xfer(name, 1'b0, key, 32'h0, 4'h0, rsp);
				check(name, model_m[key], rsp.dat);
			end
		end
	endtask

	task automatic gpio_test();
		logic [31:0] wdat;
		logic [3:0]  sel;
		wb_rsp_t     rsp;
		for (int i = 0; i < N_GPIO; i++) begin
			wdat = $urandom;
			sel  = 4'($urandom);
			bus_xfer("gpio_out", 1'b1, GPIO_BASE | 32'(GPIO_OUT_OFS), wdat, sel, rsp);
			gpio_out_m = merge_lanes(gpio_out_m, wdat, sel);
			check("gpio_out pin", gpio_out_m, gpio_out);
			bus_xfer("gpio_out", 1'b0, GPIO_BASE | 32'(GPIO_OUT_OFS), 32'h0, 4'h0, rsp);
			check("gpio_out read", gpio_out_m, rsp.dat);
		end
		for (int i = 0; i < N_GPIO; i++) begin
			wdat = $urandom;
			gpio_in <= wdat;
			// Two edges through the synchronizer.
			repeat (2) @(posedge clk);
			bus_xfer("gpio_in", 1'b0, GPIO_BASE | 32'(GPIO_IN_OFS), 32'h0, 4'h0, rsp);
			check("gpio_in read", wdat, rsp.dat);
		end
		// Spare offset acks and reads zero without touching gpio_o.
		bus_xfer("gpio_spare", 1'b1, GPIO_BASE | 32'h8, 32'hffff_ffff, 4'hf, rsp);
		check("gpio_spare ack", 32'd1, 32'(rsp.ack));
		check("gpio_spare pin", gpio_out_m, gpio_out);
		bus_xfer("gpio_spare", 1'b0, GPIO_BASE | 32'h8, 32'h0, 4'h0, rsp);
		check("gpio_spare read", 32'h0, rsp.dat);
	endtask

	task automatic unmapped_test();
		logic [31:0] adr;
		wb_rsp_t     rsp;
		for (int i = 0; i < N_BAD; i++) begin
			do begin
				adr = $urandom;
			end while (decode_region(adr) != SLV_NONE);
			bus_xfer("unmapped", 1'($urandom), adr, $urandom, 4'($urandom), rsp);
			check("unmapped err", 32'd1, 32'(rsp.err));
			check("unmapped ack", 32'd0, 32'(rsp.ack));
			check("unmapped data", 32'h0, rsp.dat);
		end
		recheck_region("unmapped ram", SLV_RAM);
		recheck_region("unmapped prg", SLV_PRG);
		check("unmapped gpio", gpio_out_m, gpio_out);
	endtask

	initial begin
		int err_start;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		wbm_req    = '0;
		gpio_in    = '0;
		gpio_out_m = '0;
		n_checks   = 0;
		n_errors   = 0;
		n_tests    = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		err_start = n_errors;
		check("reset gpio_o", 32'h0, gpio_out);
		check("reset ack", 32'd0, 32'(wbm_rsp.ack));
		check("reset err", 32'd0, 32'(wbm_rsp.err));
		finish_test("reset", err_start);

		err_start = n_errors;
		ram_traffic("data_ram", RAM_BASE, RAM_WORDS, N_RAM);
		finish_test("data_ram", err_start);

		err_start = n_errors;
		ram_traffic("prg_ram", PRG_BASE, PRG_WORDS, N_PRG);
		recheck_region("prg_ram vs data", SLV_RAM);
		finish_test("prg_ram", err_start);

		// Data writes after program writes must leave program reads alone.
		err_start = n_errors;
		ram_traffic("data_ram rewrite", RAM_BASE, RAM_WORDS, N_RAM);
		recheck_region("data_ram vs prg", SLV_PRG);
		finish_test("isolation", err_start);

		err_start = n_errors;
		gpio_test();
		finish_test("gpio", err_start);

		err_start = n_errors;
		unmapped_test();
		finish_test("unmapped", err_start);

		$display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
verilog/soc_pkg.sv
verilog/wb_addr_decoder.sv
verilog/wb_ram.sv
verilog/wb_gpio.sv
verilog/wb_resp_mux.sv
verilog/soc_top.sv
tests/soc_properties.sv
tests/tb_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SoC fabric simulation with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_soc \
	-f project.f \
	-o tb_soc_sim

./obj_dir/tb_soc_sim | tee "$LOG"

if grep -q "Test FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
echo "Simulation passed"
